// ==== design/ooo_pkg.sv ====
/*
 core-wide sizes, index types and opcodes
 16-bit instruction word with register and literal views
 pipeline structs: micro-ops, writeback lanes, commit
*/
package ooo_pkg;

	localparam int num_arch_regs = 8;
	localparam int num_phys_regs = 16;
	localparam int rob_depth     = 8;  // also the free list size (16 - 8)
	localparam int data_width    = 32;
	localparam int zero_reg      = 0;
	localparam int mul_latency   = 3;

	typedef logic [2:0] arn_t;     // architectural register
	typedef logic [3:0] prn_t;     // physical register
	typedef logic [2:0] rob_idx_t; // reorder buffer slot

	// codes 10..15 are illegal
	typedef enum logic [3:0] {
		op_add, op_sub, op_and, op_or, op_xor,
		op_sll, op_srl, op_cmpeq, op_cmplt, op_mul
	} opcode_e;

	////////////////////////////////////////
	// instruction word, lit bit picks the view
	////////////////////////////////////////
	typedef struct packed {
		opcode_e    opcode;
		arn_t       dest;
		arn_t       src_a;
		arn_t       src_b;
		logic [1:0] pad;
		logic       lit;     // 0 here
	} inst_reg_t;

	typedef struct packed {
		opcode_e    opcode;
		arn_t       dest;
		arn_t       src_a;
		logic [4:0] literal; // unsigned, zero-extended
		logic       lit;     // 1 here
	} inst_lit_t;

	typedef union packed {
		inst_reg_t reg_form;
		inst_lit_t lit_form;
	} inst_word_t;

	////////////////////////////////////////
	// pipeline structs
	////////////////////////////////////////
	typedef struct packed {
		opcode_e opcode;
		arn_t dest, src_a, src_b;
		logic use_lit;
		logic [4:0] literal;
		logic writes_dest; // false for r0 or illegal
		logic is_mul;
		logic illegal;
	} uop_t;

	typedef struct packed {
		opcode_e opcode;
		logic is_mul, use_lit;
		logic [4:0] literal;
		prn_t pa, pb;
		logic a_zero, b_zero; // operand reads r0
		prn_t pd;
		logic writes_dest;
		rob_idx_t rob_idx;
	} renamed_uop_t;

	typedef struct packed {
		logic valid;
		prn_t pd;
		logic writes_dest;
		rob_idx_t rob_idx;
		logic [data_width-1:0] value;
	} wb_t;

	typedef struct packed {
		logic valid;
		arn_t dest;
		prn_t old_pd; // freed by this commit
		logic writes_dest;
		logic [data_width-1:0] value;
		logic illegal;
	} commit_t;

endpackage

// ==== design/decode_stage.sv ====
/*
 decode stage
 input handshake, register or literal view of the word,
 opcode classification, one micro-op register
*/
`timescale 1ns/1ps

module decode_stage (
	input  logic                clock,
	input  logic                rst,
	input  logic                in_valid,
	input  ooo_pkg::inst_word_t in_inst,
	output logic                in_ready,
	output logic                out_valid,
	output ooo_pkg::uop_t       out_uop,
	input  logic                out_ready
);
	import ooo_pkg::*;

	logic running; // low through reset, keeps the input closed
	logic take;
	uop_t dec_uop;

	assign in_ready = running && (!out_valid || out_ready); // empty or draining
	assign take     = in_valid && in_ready;

	always_comb begin
		dec_uop.opcode      = in_inst.reg_form.opcode; // same bits in both views
		dec_uop.dest        = in_inst.reg_form.dest;
		dec_uop.src_a       = in_inst.reg_form.src_a;
		dec_uop.use_lit     = in_inst.reg_form.lit;
		// literal form has no src_b, point it at r0
		dec_uop.src_b       = dec_uop.use_lit ? arn_t'(zero_reg) : in_inst.reg_form.src_b;
		dec_uop.literal     = dec_uop.use_lit ? in_inst.lit_form.literal : 5'd0;
		dec_uop.illegal     = (dec_uop.opcode > op_mul); // 10..15
		dec_uop.is_mul      = (dec_uop.opcode == op_mul);
		dec_uop.writes_dest = !dec_uop.illegal && (dec_uop.dest != arn_t'(zero_reg));
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			running   <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			running <= 1'b1;
			if (take)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0; // handed on, nothing new
		end
	end

	always_ff @(posedge clock)
		if (take) out_uop <= dec_uop;

endmodule

// ==== design/rename_stage.sv ====
/*
 rename stage
 map table, free list of physical registers,
 reorder buffer allocation, renamed micro-op register
*/
`timescale 1ns/1ps

module rename_stage (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  in_valid,
	input  ooo_pkg::uop_t         in_uop,
	output logic                  in_ready,
	output logic                  out_valid,
	output ooo_pkg::renamed_uop_t out_uop,
	input  logic                  out_ready,
	input  logic                  rob_full,
	input  ooo_pkg::rob_idx_t     rob_tail,
	output logic                  alloc_valid,
	output ooo_pkg::prn_t         alloc_old_pd,
	input  ooo_pkg::commit_t      commit
);
	import ooo_pkg::*;

	prn_t     map_table [num_arch_regs];
	prn_t     free_list [rob_depth]; // sized as the rob, see pkg
	rob_idx_t fl_head, fl_tail;      // same width as a rob slot
	logic     accept;
	logic     pop, push;
	prn_t     new_pd;

	// a full rob stops everything, the free list can't run dry before it does
	assign in_ready     = !rob_full && (!out_valid || out_ready);
	assign accept       = in_valid && in_ready;
	assign alloc_valid  = accept;                     // rob entry taken on the same edge
	assign alloc_old_pd = map_table[in_uop.dest];     // mapping this write replaces
	assign new_pd       = free_list[fl_head];
	assign pop          = accept && in_uop.writes_dest;
	assign push         = commit.valid && commit.writes_dest;

	////////////////////////////////////////
	// map table and free list
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < num_arch_regs; i++)
				map_table[i] <= prn_t'(i); // identity
			for (int i = 0; i < rob_depth; i++)
				free_list[i] <= prn_t'(num_arch_regs + i); // p8..p15
			fl_head   <= '0;
			fl_tail   <= '0; // full list, head == tail
			out_valid <= 1'b0;
		end else begin
			if (pop) begin
				map_table[in_uop.dest] <= new_pd;
				fl_head                <= fl_head + 1'b1;
			end
			if (push) begin
				free_list[fl_tail] <= commit.old_pd; // retired mapping comes back
				fl_tail            <= fl_tail + 1'b1;
			end
			if (accept)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	////////////////////////////////////////
	// renamed micro-op
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (accept) begin
			out_uop.opcode      <= in_uop.opcode;
			out_uop.is_mul      <= in_uop.is_mul;
			out_uop.use_lit     <= in_uop.use_lit;
			out_uop.literal     <= in_uop.literal;
			out_uop.pa          <= map_table[in_uop.src_a]; // lookup before this write
			out_uop.pb          <= map_table[in_uop.src_b];
			out_uop.a_zero      <= (in_uop.src_a == arn_t'(zero_reg));
			out_uop.b_zero      <= (in_uop.src_b == arn_t'(zero_reg));
			out_uop.pd          <= in_uop.writes_dest ? new_pd : prn_t'(zero_reg);
			out_uop.writes_dest <= in_uop.writes_dest;
			out_uop.rob_idx     <= rob_tail; // slot allocated this edge
		end
	end

endmodule

// ==== design/issue_stage.sv ====
/*
 issue stage
 physical register values and ready bits,
 single in-order issue slot with operand read
*/
`timescale 1ns/1ps

module issue_stage (
	input  logic                                  clock,
	input  logic                                  rst,
	input  logic                                  in_valid,
	input  ooo_pkg::renamed_uop_t                 in_uop,
	output logic                                  in_ready,
	input  ooo_pkg::wb_t                          wb_alu,
	input  ooo_pkg::wb_t                          wb_mul,
	output logic                                  ex_valid,
	output ooo_pkg::renamed_uop_t                 ex_uop,
	output logic [ooo_pkg::data_width-1:0]        ex_a,
	output logic [ooo_pkg::data_width-1:0]        ex_b
);
	import ooo_pkg::*;

	logic [data_width-1:0]    prf_value [num_phys_regs];
	logic [num_phys_regs-1:0] prf_ready;
	renamed_uop_t             slot;
	logic                     slot_valid;
	logic                     a_ok, b_ok;
	logic                     load;
	wb_t [1:0]                wb_lanes;

	assign wb_lanes = {wb_mul, wb_alu};

	// no bypass, a writeback is seen the cycle after it lands
	assign a_ok     = slot.a_zero || prf_ready[slot.pa];
	assign b_ok     = slot.use_lit || slot.b_zero || prf_ready[slot.pb];
	assign ex_valid = slot_valid && a_ok && b_ok; // execute never stalls
	assign in_ready = !slot_valid || ex_valid;
	assign load     = in_valid && in_ready;
	assign ex_uop   = slot;

	assign ex_a = slot.a_zero ? '0 : prf_value[slot.pa];

	always_comb begin
		if (slot.use_lit)
			ex_b = data_width'(slot.literal); // zero-extended
		else if (slot.b_zero)
			ex_b = '0;
		else
			ex_b = prf_value[slot.pb];
	end

	////////////////////////////////////////
	// register file
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < num_phys_regs; i++)
				prf_value[i] <= '0; // architectural state starts at zero
			prf_ready  <= '1;
			slot_valid <= 1'b0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (wb_lanes[i].valid && wb_lanes[i].writes_dest) begin
					prf_value[wb_lanes[i].pd] <= wb_lanes[i].value;
					prf_ready[wb_lanes[i].pd] <= 1'b1;
				end
			end
			// new pd comes off the free list, so no writeback can race this clear
			if (load && in_uop.writes_dest)
				prf_ready[in_uop.pd] <= 1'b0;
			if (load)
				slot_valid <= 1'b1;
			else if (ex_valid)
				slot_valid <= 1'b0; // issued, slot empties
		end
	end

	always_ff @(posedge clock)
		if (load) slot <= in_uop;

endmodule

// ==== design/execute_stage.sv ====
/*
 execute stage
 single-cycle ALU on the alu lane,
 pipelined multiplier on the mul lane
*/
`timescale 1ns/1ps

module execute_stage (
	input  logic                           clock,
	input  logic                           rst,
	input  logic                           ex_valid,
	input  ooo_pkg::renamed_uop_t          ex_uop,
	input  logic [ooo_pkg::data_width-1:0] ex_a,
	input  logic [ooo_pkg::data_width-1:0] ex_b,
	output ooo_pkg::wb_t                   wb_alu,
	output ooo_pkg::wb_t                   wb_mul
);
	import ooo_pkg::*;

	logic [data_width-1:0] alu_value;
	// mul stage 0 holds operands and tag
	logic                  s0_valid;
	prn_t                  s0_pd;
	logic                  s0_wd;
	rob_idx_t              s0_rob;
	logic [data_width-1:0] s0_a, s0_b;
	wb_t                   mul_pipe [mul_latency-1]; // [0] product, last is the lane

	always_comb begin
		case (ex_uop.opcode)
			op_add:   alu_value = ex_a + ex_b;
			op_sub:   alu_value = ex_a - ex_b;
			op_and:   alu_value = ex_a & ex_b;
			op_or:    alu_value = ex_a | ex_b;
			op_xor:   alu_value = ex_a ^ ex_b;
			op_sll:   alu_value = ex_a << ex_b[4:0];
			op_srl:   alu_value = ex_a >> ex_b[4:0];
			op_cmpeq: alu_value = data_width'(ex_a == ex_b);
			op_cmplt: alu_value = data_width'($signed(ex_a) < $signed(ex_b));
			default:  alu_value = '0; // illegal codes just complete with zero
		endcase
	end

	always_ff @(posedge clock) begin
		wb_alu.pd          <= ex_uop.pd;
		wb_alu.writes_dest <= ex_uop.writes_dest;
		wb_alu.rob_idx     <= ex_uop.rob_idx;
		wb_alu.value       <= alu_value;
		s0_pd  <= ex_uop.pd;
		s0_wd  <= ex_uop.writes_dest;
		s0_rob <= ex_uop.rob_idx;
		s0_a   <= ex_a;
		s0_b   <= ex_b;
		mul_pipe[0] <= '{valid: s0_valid, pd: s0_pd, writes_dest: s0_wd,
			rob_idx: s0_rob, value: s0_a * s0_b}; // low 32 bits kept
		for (int i = 1; i < mul_latency - 1; i++)
			mul_pipe[i] <= mul_pipe[i-1];
		if (rst) begin
			wb_alu.valid <= 1'b0;
			s0_valid     <= 1'b0;
			for (int i = 0; i < mul_latency - 1; i++)
				mul_pipe[i].valid <= 1'b0;
		end else begin
			wb_alu.valid <= ex_valid && !ex_uop.is_mul;
			s0_valid     <= ex_valid && ex_uop.is_mul; // one new mul per cycle
		end
	end

	assign wb_mul = mul_pipe[mul_latency-2];

endmodule

// ==== design/reorder_buffer.sv ====
/*
 reorder buffer
 circular entries with head, tail and count,
 done flags and values from both lanes, in-order commit
*/
`timescale 1ns/1ps

module reorder_buffer (
	input  logic              clock,
	input  logic              rst,
	input  logic              alloc_valid,
	input  ooo_pkg::uop_t     alloc_uop,
	input  ooo_pkg::prn_t     alloc_old_pd,
	output logic              rob_full,
	output ooo_pkg::rob_idx_t rob_tail,
	input  ooo_pkg::wb_t      wb_alu,
	input  ooo_pkg::wb_t      wb_mul,
	output ooo_pkg::commit_t  commit
);
	import ooo_pkg::*;

	typedef logic [$clog2(rob_depth):0] count_t;

	arn_t                  ent_dest    [rob_depth];
	prn_t                  ent_old_pd  [rob_depth];
	logic                  ent_wd      [rob_depth];
	logic                  ent_illegal [rob_depth];
	logic [data_width-1:0] ent_value   [rob_depth];
	logic [rob_depth-1:0]  done;
	rob_idx_t              head, tail;
	count_t                count;
	wb_t [1:0]             wb_lanes;

	assign wb_lanes = {wb_mul, wb_alu};
	assign rob_full = (count == count_t'(rob_depth));
	assign rob_tail = tail;

	// head goes out as soon as it is done, no stall on commit
	always_comb begin
		commit.valid       = (count != '0) && done[head];
		commit.dest        = ent_dest[head];
		commit.old_pd      = ent_old_pd[head];
		commit.writes_dest = ent_wd[head];
		commit.value       = ent_value[head];
		commit.illegal     = ent_illegal[head];
	end

	////////////////////////////////////////
	// pointers and completion
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			if (alloc_valid) begin
				done[tail] <= 1'b0;
				tail       <= tail + 1'b1;
			end
			for (int i = 0; i < 2; i++)
				if (wb_lanes[i].valid) done[wb_lanes[i].rob_idx] <= 1'b1;
			if (commit.valid)
				head <= head + 1'b1;
			count <= count + count_t'(alloc_valid) - count_t'(commit.valid);
		end
	end

	always_ff @(posedge clock) begin
		if (alloc_valid) begin
			ent_dest[tail]    <= alloc_uop.dest;
			ent_old_pd[tail]  <= alloc_old_pd;
			ent_wd[tail]      <= alloc_uop.writes_dest;
			ent_illegal[tail] <= alloc_uop.illegal;
		end
		for (int i = 0; i < 2; i++)
			if (wb_lanes[i].valid) ent_value[wb_lanes[i].rob_idx] <= wb_lanes[i].value;
	end

endmodule

// ==== design/ooo_core.sv ====
/*
 core top level
 decode, rename, issue, execute and reorder buffer in a chain
*/
`timescale 1ns/1ps

module ooo_core (
	input  logic                clock,
	input  logic                rst,
	input  logic                in_valid,
	input  ooo_pkg::inst_word_t in_inst,
	output logic                in_ready,
	output ooo_pkg::commit_t    commit
);
	import ooo_pkg::*;

	logic                  dec_valid, dec_ready;  // decode -> rename
	uop_t                  dec_uop;
	logic                  ren_valid, ren_ready;  // rename -> issue
	renamed_uop_t          ren_uop;
	logic                  rob_full;
	rob_idx_t              rob_tail;
	logic                  alloc_valid;
	prn_t                  alloc_old_pd;
	logic                  ex_valid;              // issue -> execute
	renamed_uop_t          ex_uop;
	logic [data_width-1:0] ex_a, ex_b;
	wb_t                   wb_alu, wb_mul;        // two writeback lanes

	decode_stage u_decode (.clock(clock), .rst(rst),
		.in_valid(in_valid), .in_inst(in_inst), .in_ready(in_ready),
		.out_valid(dec_valid), .out_uop(dec_uop), .out_ready(dec_ready));

	rename_stage u_rename (.clock(clock), .rst(rst),
		.in_valid(dec_valid), .in_uop(dec_uop), .in_ready(dec_ready),
		.out_valid(ren_valid), .out_uop(ren_uop), .out_ready(ren_ready),
		.rob_full(rob_full), .rob_tail(rob_tail),
		.alloc_valid(alloc_valid), .alloc_old_pd(alloc_old_pd),
		.commit(commit)); // commit returns old_pd to the free list

	issue_stage u_issue (.clock(clock), .rst(rst),
		.in_valid(ren_valid), .in_uop(ren_uop), .in_ready(ren_ready),
		.wb_alu(wb_alu), .wb_mul(wb_mul),
		.ex_valid(ex_valid), .ex_uop(ex_uop), .ex_a(ex_a), .ex_b(ex_b));

	execute_stage u_execute (.clock(clock), .rst(rst),
		.ex_valid(ex_valid), .ex_uop(ex_uop), .ex_a(ex_a), .ex_b(ex_b),
		.wb_alu(wb_alu), .wb_mul(wb_mul));

	// entry fields come straight from decode on the rename edge
	reorder_buffer u_rob (.clock(clock), .rst(rst),
		.alloc_valid(alloc_valid), .alloc_uop(dec_uop), .alloc_old_pd(alloc_old_pd),
		.rob_full(rob_full), .rob_tail(rob_tail),
		.wb_alu(wb_alu), .wb_mul(wb_mul), .commit(commit));

endmodule

// ==== verification/core_assertions.sv ====
/*
 reorder buffer assertions
 quiet commit after reset, count bound, writebacks only on live entries
*/
`timescale 1ns/1ps

module core_assertions (
	input logic                                clock,
	input logic                                rst,
	input ooo_pkg::commit_t                    commit,
	input logic [$clog2(ooo_pkg::rob_depth):0] count,
	input ooo_pkg::rob_idx_t                   head,
	input ooo_pkg::wb_t                        wb_alu,
	input ooo_pkg::wb_t                        wb_mul
);
	import ooo_pkg::*;

	// reset empties the buffer, nothing can retire on the next cycle
	commit_quiet_after_reset: assert property (@(posedge clock) rst |=> !commit.valid)
		else $error("commit.valid high in the cycle after reset");

	count_in_range: assert property (@(posedge clock) disable iff (rst) count <= rob_depth)
		else $error("reorder buffer count above its depth");

	// done only ever lands on an allocated entry, so a done head really wrote back
	alu_wb_live: assert property (@(posedge clock) disable iff (rst)
		wb_alu.valid |-> rob_idx_t'(wb_alu.rob_idx - head) < count)
		else $error("alu writeback to a reorder buffer entry that is not allocated");

	mul_wb_live: assert property (@(posedge clock) disable iff (rst)
		wb_mul.valid |-> rob_idx_t'(wb_mul.rob_idx - head) < count)
		else $error("mul writeback to a reorder buffer entry that is not allocated");

endmodule

bind reorder_buffer core_assertions u_rob_checks (.clock(clock), .rst(rst), .commit(commit),
	.count(count), .head(head), .wb_alu(wb_alu), .wb_mul(wb_mul));

// ==== verification/core_checker.sv ====
/*
 commit checker
 queue of accepted words, 8-register reference model,
 in-order comparison of every commit, running counts
*/
`timescale 1ns/1ps

module core_checker (
	input  logic                clock,
	input  logic                rst,
	input  logic                in_valid,
	input  logic                in_ready,
	input  ooo_pkg::inst_word_t in_inst,
	input  ooo_pkg::commit_t    commit,
	output int                  pass_count,
	output int                  fail_count,
	output int                  accepted_count,
	output int                  commit_count
);
	import ooo_pkg::*;

	inst_word_t               pending [$];              // accepted, not yet retired
	logic [data_width-1:0]    arch_reg [num_arch_regs];
	logic                     was_in_reset;
	logic [num_arch_regs-1:0] identity_map;             // register still maps to its reset reg
	int                       last_write [num_arch_regs]; // commit number of last retired write
	int                       last_free  [num_phys_regs]; // commit number when last freed

	// opcode rules, codes 10..15 give zero
	function automatic logic [data_width-1:0] reference_result(logic [3:0] op,
		logic [data_width-1:0] a, logic [data_width-1:0] b);
		case (op)
			op_add:   return a + b;
			op_sub:   return a - b;
			op_and:   return a & b;
			op_or:    return a | b;
			op_xor:   return a ^ b;
			op_sll:   return a << b[4:0];
			op_srl:   return a >> b[4:0];
			op_cmpeq: return (a == b) ? 32'd1 : 32'd0;
			op_cmplt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; // signed
			op_mul:   return a * b;                                     // low word only
			default:  return '0;
		endcase
	endfunction

	function automatic logic [data_width-1:0] read_reg(arn_t r);
		return (r == arn_t'(zero_reg)) ? '0 : arch_reg[r]; // r0 reads zero
	endfunction

	// a retiring write frees the register its dest held before
	function automatic logic freed_pd_ok(arn_t r, prn_t p);
		if (identity_map[r] && p !== prn_t'(r))
			return 1'b0; // first write after reset frees p_r
		for (int s = 0; s < num_arch_regs; s++)
			if (s != r && identity_map[s] && p === prn_t'(s))
				return 1'b0; // still held by an unwritten register, p0 included
		return (last_write[r] > last_free[p]); // recycled only through a retired write of r
	endfunction

	// sampled mid-cycle, everything is settled here
	always @(negedge clock) begin : compare
		inst_word_t            w;
		logic [data_width-1:0] a, b, exp_value;
		logic                  exp_illegal, exp_wd;
		logic                  value_ok, pd_ok;
		if (rst) begin
			pending.delete();
			foreach (arch_reg[i]) arch_reg[i] = '0;
			identity_map = '1;
			foreach (last_write[i]) last_write[i] = -1;
			foreach (last_free[i]) last_free[i] = (i < num_arch_regs) ? -2 : -1; // p8..p15 free
			pass_count     = 0;
			fail_count     = 0;
			accepted_count = 0;
			commit_count   = 0;
			was_in_reset   = 1'b1;
		end else begin
			if (was_in_reset && commit.valid) begin
				fail_count++;
				$display("commit.valid was high in the first cycle after reset");
			end
			was_in_reset = 1'b0;
			if (in_valid && in_ready) begin // transfer on the coming edge
				pending.push_back(in_inst);
				accepted_count++;
			end
			if (commit.valid) begin
				commit_count++;
				if (pending.size() == 0) begin
					fail_count++;
					$display("test %0d: a commit arrived with no accepted instruction left",
						commit_count);
				end else begin
					w           = pending.pop_front();
					exp_illegal = (w.reg_form.opcode >= 4'd10);
					exp_wd      = !exp_illegal && (w.reg_form.dest != arn_t'(zero_reg));
					a           = read_reg(w.reg_form.src_a);
					b           = w.reg_form.lit ? data_width'(w.lit_form.literal)
						: read_reg(w.reg_form.src_b);
					exp_value   = reference_result(w.reg_form.opcode, a, b);
					value_ok    = (commit.dest === w.reg_form.dest)
						&& (commit.illegal === exp_illegal)
						&& (commit.writes_dest === exp_wd) && (commit.value === exp_value);
					pd_ok       = !exp_wd || freed_pd_ok(w.reg_form.dest, commit.old_pd);
					if (!value_ok) begin
						fail_count++;
						$display("FAILED at %0t: test %0d op %0d got r%0d=%h ill %b, want r%0d=%h ill %b",
							$time, commit_count, w.reg_form.opcode, commit.dest, commit.value,
							commit.illegal, w.reg_form.dest, exp_value, exp_illegal);
					end else if (pd_ok !== 1'b1) begin
						fail_count++;
						$display("FAILED at %0t: test %0d r%0d freed p%0d, not the register it held",
							$time, commit_count, w.reg_form.dest, commit.old_pd);
					end else begin
						pass_count++;
						$display("test %0d passed: op %0d r%0d = %h", commit_count,
							w.reg_form.opcode, w.reg_form.dest, exp_value);
					end
					if (exp_wd) begin
						arch_reg[w.reg_form.dest]     = exp_value; // model, not DUT value
						identity_map[w.reg_form.dest] = 1'b0;
						last_write[w.reg_form.dest]   = commit_count;
						last_free[commit.old_pd]      = commit_count;
					end
				end
			end
		end
	end

endmodule

// ==== verification/core_tb.sv ====
/*
 core testbench
 clock and reset, seeded random instruction stream,
 commit checker instance, drain and closing summary
*/
`timescale 1ns/1ps

module core_tb;
	import ooo_pkg::*;

	logic       clock;
	logic       rst;
	logic       in_valid;
	inst_word_t in_inst;
	logic       in_ready;
	commit_t    commit;
	int         pass_count, fail_count, accepted_count, commit_count;
	int         mul_run;    // multiplies left in the current run
	arn_t       last_dest;  // feeds dependent chains

	ooo_core uut (.clock(clock), .rst(rst), .in_valid(in_valid), .in_inst(in_inst),
		.in_ready(in_ready), .commit(commit));

	core_checker u_checker (.clock(clock), .rst(rst), .in_valid(in_valid),
		.in_ready(in_ready), .in_inst(in_inst), .commit(commit),
		.pass_count(pass_count), .fail_count(fail_count),
		.accepted_count(accepted_count), .commit_count(commit_count));

	initial clock = 1'b0;
	always #50 clock = ~clock; // 100 ns period

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	function automatic inst_word_t next_word();
		logic [3:0] op;
		arn_t       dest, src_a;
		logic [4:0] field;          // src_b and pad, or the literal
		int         pick;
		pick = $urandom_range(99);
		if (mul_run > 0) begin
			op = op_mul;
			mul_run--;
		end else if (pick < 12) begin
			op      = op_mul;
			mul_run = $urandom_range(4, 1); // start a run
		end else if (pick < 18)
			op = 4'($urandom_range(15, 10)); // illegal codes
		else
			op = 4'($urandom_range(8));
		dest  = ($urandom_range(9) == 0) ? arn_t'(zero_reg) : arn_t'($urandom_range(7));
		src_a = ($urandom_range(2) == 0) ? last_dest : arn_t'($urandom_range(7));
		field = 5'($urandom);
		last_dest = dest;
		return {op, dest, src_a, field, 1'($urandom)};
	endfunction

	task automatic drive_program(input int count, output logic stalled);
		int   sent;
		int   idle;
		logic fire;
		sent    = 0;
		idle    = 0;
		stalled = 1'b0;
		in_inst = next_word();
		while (sent < count && !stalled) begin
			@(negedge clock);
			fire = in_valid && in_ready; // transfer on the next rising edge
			@(posedge clock);
			#10;
			if (fire) begin
				sent++;
				idle = 0;
				if (sent < count) in_inst = next_word(); // new word only after accept
			end else if (in_valid) begin
				idle++;
				if (idle > 200) stalled = 1'b1;
			end
			in_valid = (sent < count) && ($urandom_range(99) < 70);
		end
		in_valid = 1'b0;
	endtask

	task automatic wait_drain(output logic drained);
		int cycles;
		cycles = 0;
		while (commit_count < accepted_count && cycles < 2000) begin
			@(posedge clock);
			cycles++;
		end
		drained = (commit_count >= accepted_count);
	endtask

	////////////////////////////////////////
	// run
	////////////////////////////////////////
	initial begin
		logic stalled, drained;
		void'($urandom(32'h1df1_ec1e)); // seeds the generator once
		rst       = 1'b1;
		in_valid  = 1'b0;
		in_inst   = '0;
		mul_run   = 0;
		last_dest = '0;
		repeat (3) @(posedge clock);
		#10 rst = 1'b0;
		drive_program(400, stalled);
		wait_drain(drained);
		repeat (10) @(posedge clock); // a duplicate commit would show up here
		if (stalled)
			$display("stimulus stopped: in_ready stayed low for more than 200 cycles");
		if (!drained)
			$display("drain timed out: only %0d of %0d accepted instructions committed",
				commit_count, accepted_count);
		else if (commit_count != accepted_count)
			$display("commit count %0d does not match accepted count %0d",
				commit_count, accepted_count);
		$display("summary: %0d passed, %0d failed, %0d accepted, %0d committed",
			pass_count, fail_count, accepted_count, commit_count);
		if (!stalled && drained && fail_count == 0 && commit_count == accepted_count
			&& accepted_count == 400)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
design/ooo_pkg.sv
design/decode_stage.sv
design/rename_stage.sv
design/issue_stage.sv
design/execute_stage.sv
design/reorder_buffer.sv
design/ooo_core.sv
verification/core_assertions.sv
verification/core_checker.sv
verification/core_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - design/ooo_pkg.sv
  - design/decode_stage.sv
  - design/rename_stage.sv
  - design/issue_stage.sv
  - design/execute_stage.sv
  - design/reorder_buffer.sv
  - design/ooo_core.sv
  - target: simulation
    files:
      - verification/core_assertions.sv
      - verification/core_checker.sv
      - verification/core_tb.sv
